/* source/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  // Command opcode is the first byte of every packet
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02
  } opcode_e;

  // Parser walks one state per input byte outside the read and error states
  typedef enum logic [2:0] {
    ST_OPCODE,
    ST_ADDR,
    ST_WDATA,
    ST_COUNT,
    ST_READ,  // Issuing bank reads while input stalls
    ST_DRAIN, // Discarding a bad packet
    ST_ERR    // Queueing the error reply while input stalls
  } parse_state_e;

  // Single-byte reply to an unknown or malformed command
  localparam logic [7:0] ERR_BYTE = 8'hEE;

  // Width of the reply credit count between framer and parser
  localparam int unsigned CREDIT_W = 8;

endpackage : bridge_pkg

`default_nettype wire

/* source/mem_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_bank #(
  parameter int BANK_AW = 6
) (
  input  wire logic               clock,
  input  wire logic               rst_i,
  input  wire logic               wr_en_i,
  input  wire logic               rd_en_i,
  input  wire logic               last_i,
  input  wire logic [BANK_AW-1:0] index_i,
  input  wire logic [7:0]         wdata_i,
  output logic                    rd_valid_o,
  output logic                    rd_last_o,
  output logic [7:0]              rd_data_o
);

  localparam int DEPTH = 1 << BANK_AW;

  logic [7:0] mem [DEPTH];

  // Storage and read data path
  always_ff @(posedge clock) begin
    if (wr_en_i) begin
      mem[index_i] <= wdata_i;
    end
    if (rd_en_i) begin
      rd_data_o <= mem[index_i];
      rd_last_o <= last_i;  // Tag travels with the byte
    end
  end

  // Read valid follows the read strobe one cycle later
  always_ff @(posedge clock) begin
    if (rst_i) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_en_i;
    end
  end

  // The parser serves one byte per cycle, so both ports never collide
  a_no_rw_collision : assert property (
    @(posedge clock) disable iff (rst_i)
    !(wr_en_i && rd_en_i)
  ) else $error("mem_bank: write and read requested in the same cycle");

endmodule : mem_bank

`default_nettype wire

/* source/cmd_parser.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_parser
  import bridge_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int ADDR_WIDTH = 8,
  parameter int BANK_AW    = 6
) (
  input  wire logic                  clock,
  input  wire logic                  rst_i,
  input  wire logic                  s_tvalid_i,
  output logic                       s_tready_o,
  input  wire logic                  s_tlast_i,
  input  wire logic [7:0]            s_tdata_i,
  input  wire logic [CREDIT_W-1:0]   credit_i,
  output logic [NUM_BANKS-1:0]       bank_wr_en_o,
  output logic [NUM_BANKS-1:0]       bank_rd_en_o,
  output logic [BANK_AW-1:0]         bank_index_o,
  output logic [7:0]                 bank_wdata_o,
  output logic                       bank_last_o,
  output logic                       err_push_o
);

  localparam int SEL_W = ADDR_WIDTH - BANK_AW;  // Low address bits pick the bank

  parse_state_e          state;
  opcode_e               op;
  logic [ADDR_WIDTH-1:0] addr;
  logic [8:0]            count;  // Zero count byte means 256
  logic                  err_q;
  logic                  iss1, iss2;
  logic [1:0]            inflight;
  logic                  credit_ok;
  logic                  xfer;
  logic [SEL_W-1:0]      sel;
  logic [BANK_AW-1:0]    idx;
  logic [NUM_BANKS-1:0]  bank_hot;

  assign s_tready_o = (state != ST_READ) && (state != ST_ERR);
  assign xfer       = s_tvalid_i && s_tready_o;

  assign sel      = addr[SEL_W-1:0];
  assign idx      = addr[ADDR_WIDTH-1:SEL_W];
  assign bank_hot = NUM_BANKS'(1) << sel;

  // Issues still on their way to the reply FIFO have already taken a slot
  assign iss1      = (|bank_rd_en_o) || err_q;
  assign inflight  = {1'b0, iss1} + {1'b0, iss2};
  assign credit_ok = credit_i > CREDIT_W'(inflight);

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state        <= ST_OPCODE;
      bank_wr_en_o <= '0;
      bank_rd_en_o <= '0;
      err_q        <= 1'b0;
      err_push_o   <= 1'b0;
      iss2         <= 1'b0;
    end else begin
      bank_wr_en_o <= '0;
      bank_rd_en_o <= '0;
      err_q        <= 1'b0;
      err_push_o   <= err_q;  // Extra stage matches the bank read latency
      iss2         <= iss1;

      case (state)
        ST_OPCODE: begin
          if (xfer) begin
            if (s_tdata_i == OP_WRITE || s_tdata_i == OP_READ) begin
              state <= s_tlast_i ? ST_OPCODE : ST_ADDR;  // Bare opcode is ignored
            end else begin
              state <= s_tlast_i ? ST_ERR : ST_DRAIN;
            end
          end
        end
        ST_ADDR: begin
          if (xfer) begin
            if (s_tlast_i) begin
              state <= ST_OPCODE;
            end else if (op == OP_WRITE) begin
              state <= ST_WDATA;
            end else begin
              state <= ST_COUNT;
            end
          end
        end
        ST_WDATA: begin
          if (xfer) begin
            bank_wr_en_o <= bank_hot;
            if (s_tlast_i) begin
              state <= ST_OPCODE;
            end
          end
        end
        ST_COUNT: begin
          if (xfer) begin
            state <= s_tlast_i ? ST_READ : ST_DRAIN;  // Trailing bytes make it malformed
          end
        end
        ST_READ: begin
          if (credit_ok) begin
            bank_rd_en_o <= bank_hot;
            if (count == 9'd1) begin
              state <= ST_OPCODE;
            end
          end
        end
        ST_DRAIN: begin
          if (xfer && s_tlast_i) begin
            state <= ST_ERR;
          end
        end
        ST_ERR: begin
          if (credit_ok) begin
            err_q <= 1'b1;
            state <= ST_OPCODE;
          end
        end
        default: state <= ST_OPCODE;
      endcase
    end
  end

  // Address, count and bank payload
  always_ff @(posedge clock) begin
    case (state)
      ST_OPCODE: if (xfer) op <= opcode_e'(s_tdata_i);
      ST_ADDR:   if (xfer) addr <= ADDR_WIDTH'(s_tdata_i);
      ST_WDATA: begin
        if (xfer) begin
          bank_index_o <= idx;
          bank_wdata_o <= s_tdata_i;
          addr         <= addr + 1'b1;  // Wraps at the top of memory
        end
      end
      ST_COUNT: if (xfer) count <= {s_tdata_i == 8'd0, s_tdata_i};
      ST_READ: begin
        if (credit_ok) begin
          bank_index_o <= idx;
          bank_last_o  <= (count == 9'd1);
          addr         <= addr + 1'b1;
          count        <= count - 1'b1;
        end
      end
      default: ;
    endcase
  end

  a_strobes_onehot : assert property (
    @(posedge clock) disable iff (rst_i)
    $onehot0(bank_wr_en_o) && $onehot0(bank_rd_en_o) &&
    !((|bank_wr_en_o) && (|bank_rd_en_o))
  ) else $error("cmd_parser: bank strobes not one-hot, state %s", state.name());

endmodule : cmd_parser

`default_nettype wire

/* source/reply_framer.sv */
`timescale 1ns/100ps
`default_nettype none

module reply_framer
  import bridge_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic                      clock,
  input  wire logic                      rst_i,
  input  wire logic [NUM_BANKS-1:0]      rd_valid_i,
  input  wire logic [NUM_BANKS-1:0]      rd_last_i,
  input  wire logic [NUM_BANKS-1:0][7:0] rd_data_i,
  input  wire logic                      err_push_i,
  output logic                           m_tvalid_o,
  input  wire logic                      m_tready_i,
  output logic                           m_tlast_o,
  output logic [7:0]                     m_tdata_o,
  output logic [CREDIT_W-1:0]            credit_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [7:0]       fifo_data [FIFO_DEPTH];
  logic             fifo_last [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push, pop, full;
  logic [7:0]       push_data, ret_data;
  logic             push_last, ret_last;

  // At most one bank answers per cycle, so a plain scan picks it
  always_comb begin
    ret_data = '0;
    ret_last = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (rd_valid_i[b]) begin
        ret_data = rd_data_i[b];
        ret_last = rd_last_i[b];
      end
    end
  end

  assign push      = (|rd_valid_i) || err_push_i;
  assign push_data = err_push_i ? ERR_BYTE : ret_data;
  assign push_last = err_push_i || ret_last;  // Error reply is a one-byte packet

  assign full = (count == CNT_W'(FIFO_DEPTH));
  assign pop  = m_tvalid_o && m_tready_i;

  assign m_tvalid_o = (count != '0);
  assign m_tdata_o  = fifo_data[rd_ptr];  // Head stays put while stalled
  assign m_tlast_o  = fifo_last[rd_ptr];

  // Free slots that the parser reduces by its own issues in flight
  assign credit_o = CREDIT_W'(FIFO_DEPTH) - CREDIT_W'(count);

  always_ff @(posedge clock) begin
    if (push) begin
      fifo_data[wr_ptr] <= push_data;
      fifo_last[wr_ptr] <= push_last;
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_single_source : assert property (
    @(posedge clock) disable iff (rst_i)
    $onehot0({rd_valid_i, err_push_i})
  ) else $error("reply_framer: more than one reply source in a cycle");

  // Credit handshake with the parser must keep the FIFO from overflowing
  a_no_overflow : assert property (
    @(posedge clock) disable iff (rst_i)
    push |-> !full
  ) else $error("reply_framer: push into a full FIFO");

endmodule : reply_framer

`default_nettype wire

/* source/usb_mem_bridge_top.sv */
`timescale 1ns/100ps
`default_nettype none

module usb_mem_bridge_top
  import bridge_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int ADDR_WIDTH = 8,
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic       clock,
  input  wire logic       rst_i,

  input  wire logic       s_tvalid_i,  // Command stream from BULK OUT
  output logic            s_tready_o,
  input  wire logic       s_tlast_i,
  input  wire logic [7:0] s_tdata_i,

  output logic            m_tvalid_o,  // Reply stream toward BULK IN
  input  wire logic       m_tready_i,
  output logic            m_tlast_o,
  output logic [7:0]      m_tdata_o
);

  localparam int BANK_AW = ADDR_WIDTH - $clog2(NUM_BANKS);

  logic [NUM_BANKS-1:0]      bank_wr_en, bank_rd_en;
  logic [BANK_AW-1:0]        bank_index;
  logic [7:0]                bank_wdata;
  logic                      bank_last;
  logic [NUM_BANKS-1:0]      rd_valid, rd_last;
  logic [NUM_BANKS-1:0][7:0] rd_data;
  logic                      err_push;
  logic [CREDIT_W-1:0]       credit;

  cmd_parser #(
    .NUM_BANKS (NUM_BANKS),
    .ADDR_WIDTH(ADDR_WIDTH),
    .BANK_AW   (BANK_AW)
  ) u_parser (
    .clock       (clock),
    .rst_i       (rst_i),
    .s_tvalid_i  (s_tvalid_i),
    .s_tready_o  (s_tready_o),
    .s_tlast_i   (s_tlast_i),
    .s_tdata_i   (s_tdata_i),
    .credit_i    (credit),
    .bank_wr_en_o(bank_wr_en),
    .bank_rd_en_o(bank_rd_en),
    .bank_index_o(bank_index),
    .bank_wdata_o(bank_wdata),
    .bank_last_o (bank_last),
    .err_push_o  (err_push)
  );

  // Byte-interleaved banks standing in for the DDR3 core
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    mem_bank #(
      .BANK_AW(BANK_AW)
    ) u_bank (
      .clock     (clock),
      .rst_i     (rst_i),
      .wr_en_i   (bank_wr_en[g]),
      .rd_en_i   (bank_rd_en[g]),
      .last_i    (bank_last),
      .index_i   (bank_index),
      .wdata_i   (bank_wdata),
      .rd_valid_o(rd_valid[g]),
      .rd_last_o (rd_last[g]),
      .rd_data_o (rd_data[g])
    );
  end

  reply_framer #(
    .NUM_BANKS (NUM_BANKS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_framer (
    .clock     (clock),
    .rst_i     (rst_i),
    .rd_valid_i(rd_valid),
    .rd_last_i (rd_last),
    .rd_data_i (rd_data),
    .err_push_i(err_push),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o),
    .credit_o  (credit)
  );

endmodule : usb_mem_bridge_top

`default_nettype wire

/* verification/tb_usb_mem_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_usb_mem_bridge
  import bridge_pkg::*;
();

  localparam int unsigned SEED        = 32'h2bd5f36d;
  localparam int          N_DIRECTED  = 14;
  localparam int          N_RANDOM    = 40;
  localparam int          N_PACKETS   = N_DIRECTED + N_RANDOM;
  localparam longint      WATCHDOG_NS = longint'(N_PACKETS) * 600 * 100;

  logic       clock = 1'b0;
  logic       rst_i;
  logic       s_tvalid_i, s_tready_o, s_tlast_i;
  logic [7:0] s_tdata_i;
  logic       m_tvalid_o, m_tready_i, m_tlast_o;
  logic [7:0] m_tdata_o;

  logic [7:0] ref_mem [256];  // Expected memory contents
  logic [7:0] exp_data_q [$];
  logic       exp_last_q [$];
  logic [7:0] head_data;
  logic       head_last;
  logic       head_ok = 1'b0;
  logic       fire_n = 1'b0;
  logic       rst_q = 1'b0;
  logic       stall_q = 1'b0;
  logic [7:0] held_data;
  logic       held_last;
  int         err_value = 0;
  int         err_other = 0;
  int         bytes_checked = 0;

  usb_mem_bridge_top DUT (
    .clock     (clock),
    .rst_i     (rst_i),
    .s_tvalid_i(s_tvalid_i),
    .s_tready_o(s_tready_o),
    .s_tlast_i (s_tlast_i),
    .s_tdata_i (s_tdata_i),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o)
  );

  always #50 clock = ~clock;

  // BULK IN side refuses about 30 percent of the cycles
  initial begin
    m_tready_i = 1'b0;
    forever begin
      @(posedge clock);
      m_tready_i <= ($urandom_range(99) >= 30);
    end
  end

  // Head of the expected reply is taken while the bus is quiet
  always @(negedge clock) begin
    head_ok   = (exp_data_q.size() != 0);
    head_data = head_ok ? exp_data_q[0] : 8'h00;
    head_last = head_ok ? exp_last_q[0] : 1'b0;
    fire_n    = !rst_i && m_tvalid_o && m_tready_i;
  end

  always @(posedge clock) begin
    rst_q     <= rst_i;
    stall_q   <= m_tvalid_o && !m_tready_i;
    held_data <= m_tdata_o;
    held_last <= m_tlast_o;
    if (fire_n && head_ok) begin
      bytes_checked++;
      void'(exp_data_q.pop_front());
      void'(exp_last_q.pop_front());
    end
  end

  a_reply_expected : assert property (@(posedge clock) disable iff (rst_i)
    (m_tvalid_o && m_tready_i) |-> head_ok
  ) else begin
    err_other++;
    $display("%0t: reply byte %02h sent while no reply was pending", $time, m_tdata_o);
  end

  a_reply_data : assert property (@(posedge clock) disable iff (rst_i)
    (m_tvalid_o && m_tready_i && head_ok) |-> (m_tdata_o == head_data)
  ) else begin
    err_value++;
    $display("ERR %0t m_tdata_o expected %02h actual %02h", $time, head_data, m_tdata_o);
  end

  a_reply_last : assert property (@(posedge clock) disable iff (rst_i)
    (m_tvalid_o && m_tready_i && head_ok) |-> (m_tlast_o == head_last)
  ) else begin
    err_value++;
    $display("ERR %0t m_tlast_o expected %b actual %b", $time, head_last, m_tlast_o);
  end

  // A stalled byte must stay put until it is taken
  a_hold_valid : assert property (@(posedge clock) disable iff (rst_i)
    stall_q |-> m_tvalid_o
  ) else begin
    err_other++;
    $display("%0t: m_tvalid_o dropped before the stalled byte was taken", $time);
  end

  a_hold_data : assert property (@(posedge clock) disable iff (rst_i)
    stall_q |-> (m_tdata_o == held_data)
  ) else begin
    err_value++;
    $display("ERR %0t m_tdata_o expected %02h actual %02h", $time, held_data, m_tdata_o);
  end

  a_hold_last : assert property (@(posedge clock) disable iff (rst_i)
    stall_q |-> (m_tlast_o == held_last)
  ) else begin
    err_value++;
    $display("ERR %0t m_tlast_o expected %b actual %b", $time, held_last, m_tlast_o);
  end

  a_reset_valid : assert property (@(posedge clock) rst_q |-> !m_tvalid_o)
  else begin
    err_value++;
    $display("ERR %0t m_tvalid_o expected 0 actual %b", $time, m_tvalid_o);
  end

  a_reset_ready : assert property (@(posedge clock) rst_q |-> s_tready_o)
  else begin
    err_value++;
    $display("ERR %0t s_tready_o expected 1 actual %b, parser in %s", $time, s_tready_o,
             DUT.u_parser.state.name());
  end

  // Holds the byte until the edge where the parser takes it
  task automatic send_byte(input logic [7:0] data, input logic last);
    logic done;
    s_tvalid_i <= 1'b1;
    s_tdata_i  <= data;
    s_tlast_i  <= last;
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      done = s_tready_o;
      @(posedge clock);
    end
  endtask

  task automatic idle_cycles(input int n);
    s_tvalid_i <= 1'b0;
    s_tlast_i  <= 1'b0;
    repeat (n) @(posedge clock);
  endtask

  task automatic write_packet(input logic [7:0] addr, input int len);
    logic [7:0] a;
    logic [7:0] d;
    a = addr;
    send_byte(OP_WRITE, 1'b0);
    send_byte(addr, 1'b0);
    for (int i = 0; i < len; i++) begin
      d = 8'($urandom);
      send_byte(d, i == len - 1);
      ref_mem[a] = d;
      a = a + 8'd1;  // Wraps past 255
    end
  endtask

  task automatic read_packet(input logic [7:0] addr, input logic [7:0] count);
    int         n;
    logic [7:0] a;
    n = (count == 8'd0) ? 256 : int'(count);
    a = addr;
    send_byte(OP_READ, 1'b0);
    send_byte(addr, 1'b0);
    send_byte(count, 1'b1);
    for (int i = 0; i < n; i++) begin
      exp_data_q.push_back(ref_mem[a]);
      exp_last_q.push_back(i == n - 1);
      a = a + 8'd1;
    end
  endtask

  task automatic bad_packet(input int len);
    logic [7:0] op;
    op = 8'($urandom);
    while (op == OP_WRITE || op == OP_READ) begin
      op = 8'($urandom);
    end
    send_byte(op, len == 1);
    for (int i = 1; i < len; i++) begin
      send_byte(8'($urandom), i == len - 1);
    end
    exp_data_q.push_back(ERR_BYTE);  // One-byte error reply
    exp_last_q.push_back(1'b1);
  endtask

  task automatic random_packet();
    int kind;
    kind = $urandom_range(2);
    case (kind)
      0:       write_packet(8'($urandom), $urandom_range(32, 1));
      1:       read_packet(8'($urandom), 8'($urandom_range(32, 1)));
      default: bad_packet($urandom_range(6, 1));
    endcase
  endtask

  initial begin
    int         wait_cycles;
    logic [7:0] addr;
    int         len;
    void'($urandom(SEED));
    rst_i      = 1'b1;
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
    s_tdata_i  = 8'h00;
    repeat (4) @(posedge clock);
    rst_i <= 1'b0;
    @(posedge clock);

    write_packet(8'h00, 256);  // Known contents everywhere
    idle_cycles(3);
    repeat (3) begin
      addr = 8'($urandom);
      len  = $urandom_range(32, 1);
      write_packet(addr, len);
      read_packet(addr, 8'(len));
      idle_cycles(2);
    end

    // Span all banks and cross from 255 to 0
    write_packet(8'hFC, 8);
    read_packet(8'hFC, 8'd8);
    read_packet(8'hFE, 8'd6);

    bad_packet($urandom_range(8, 1));
    read_packet(8'h00, 8'd0);  // Whole memory as count 0 means 256
    bad_packet(1);
    read_packet(8'($urandom), 8'd64);

    repeat (N_RANDOM) random_packet();  // Back to back with no idle cycles

    idle_cycles(1);
    wait_cycles = 0;
    while ((exp_data_q.size() != 0 || m_tvalid_o) && wait_cycles < 2000) begin
      @(posedge clock);
      wait_cycles++;
    end
    idle_cycles(20);  // Room for stray extra bytes
    if (exp_data_q.size() != 0) begin
      err_other++;
      $display("Reply stream stopped with %0d bytes still expected", exp_data_q.size());
    end

    $display("Summary: %0d value errors, %0d other errors, %0d reply bytes checked",
             err_value, err_other, bytes_checked);
    if (err_value + err_other == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Budget of 600 cycles per packet
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d reply bytes checked, run stopped",
             WATCHDOG_NS, bytes_checked);
    $display("TB FAILED");
    $finish;
  end

endmodule : tb_usb_mem_bridge

`default_nettype wire

/* build.f */
source/bridge_pkg.sv
source/mem_bank.sv
source/cmd_parser.sv
source/reply_framer.sv
source/usb_mem_bridge_top.sv
verification/tb_usb_mem_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the run from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_usb_mem_bridge -Mdir obj_dir -o tb_usb_mem_bridge \
  -f build.f

status=0
./obj_dir/tb_usb_mem_bridge > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
